//--- cache_pkg.sv
package cache_pkg;

    // one core data or address word
    typedef logic [31:0] word_t;

    // one enable bit per byte lane of a word
    typedef logic [3:0] byte_en_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,         // clear sweep after reset
        HIT,          // serving core requests
        FETCH,        // block fill from memory
        WB,           // dirty victim going out
        FLUSH_CACHE   // write back and clear every frame
    } cache_state_t;

    // default geometry, overridden at the top level
    localparam int DEF_CACHE_BYTES = 256;   // data bytes only
    localparam int DEF_BLOCK_WORDS = 2;     // power of 2
    localparam int DEF_ASSOC       = 2;     // 1 or 2

    // addresses from here up bypass the cache
    localparam word_t DEF_NONCACHE_START = 32'hF000_0000;

endpackage

//--- cache_sram.sv
`timescale 1ns/1ns

module cache_sram #(
    parameter int N_SETS = 16,
    parameter int SET_W  = 182   // ASSOC frames side by side
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic [$clog2(N_SETS)-1:0] sel,
    input  logic                      wen,
    input  logic [SET_W-1:0]          wval,
    input  logic [SET_W-1:0]          wmask,   // a zero bit takes wval
    output logic [SET_W-1:0]          rval
);

    logic [SET_W-1:0] rows [N_SETS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < N_SETS; i++) begin
                rows[i] <= '0;
            end
        end else if (wen) begin
            // masked bits keep their old value
            rows[sel] <= (rows[sel] & wmask) | (wval & ~wmask);
        end
    end

    assign rval = rows[sel];   // read follows sel in the same cycle

endmodule

//--- cache_lookup.sv
`timescale 1ns/1ns

module cache_lookup import cache_pkg::*; #(
    parameter int   N_SETS      = 16,
    parameter int   BLOCK_WORDS = 2,
    parameter int   ASSOC       = 2,
    parameter int   TAG_BITS    = 25,
    localparam int  FRAME_W     = BLOCK_WORDS * 32 + TAG_BITS + 2,
    localparam int  WAY_W       = (ASSOC > 1) ? $clog2(ASSOC) : 1
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic [ASSOC*FRAME_W-1:0] rval,
    input  word_t                    addr,
    input  logic                     touch,
    output logic                     hit,
    output logic [WAY_W-1:0]         hit_way,
    output word_t                    hit_word,
    output logic [WAY_W-1:0]         victim_way,
    output logic                     victim_dirty,
    output logic [TAG_BITS-1:0]      victim_tag
);

    localparam int DATA_W = BLOCK_WORDS * 32;
    localparam int OFF_W  = $clog2(BLOCK_WORDS);
    localparam int IDX_W  = $clog2(N_SETS);

    logic [IDX_W-1:0]    set_idx;
    logic [TAG_BITS-1:0] addr_tag;
    word_t               word_off;
    logic [FRAME_W-1:0]  frame [ASSOC];
    logic [WAY_W-1:0]    last_used [N_SETS];   // most recent way per set

    assign set_idx  = addr[2+OFF_W +: IDX_W];
    assign addr_tag = addr[31 -: TAG_BITS];
    assign word_off = (addr >> 2) & word_t'(BLOCK_WORDS - 1);

    // frame layout: valid, dirty, tag, data
    always_comb begin
        for (int w = 0; w < ASSOC; w++) begin
            frame[w] = rval[w*FRAME_W +: FRAME_W];
        end
    end

    always_comb begin
        hit      = 1'b0;
        hit_way  = '0;
        hit_word = '0;
        for (int w = 0; w < ASSOC; w++) begin
            if (frame[w][FRAME_W-1] && frame[w][DATA_W +: TAG_BITS] == addr_tag) begin
                hit      = 1'b1;
                hit_way  = WAY_W'(w);
                hit_word = frame[w][word_off*32 +: 32];
            end
        end
    end

    // not-recently-used: evict the way that was not touched last
    assign victim_way   = (ASSOC == 1) ? '0 : WAY_W'(last_used[set_idx] + 1'b1);
    assign victim_dirty = frame[victim_way][FRAME_W-1] && frame[victim_way][FRAME_W-2];
    assign victim_tag   = frame[victim_way][DATA_W +: TAG_BITS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                last_used[s] <= '0;
            end
        end else if (touch) begin
            last_used[set_idx] <= hit_way;
        end
    end

endmodule

//--- cache_ctrl.sv
`timescale 1ns/1ns

module cache_ctrl import cache_pkg::*; #(
    parameter int    N_SETS         = 16,
    parameter int    BLOCK_WORDS    = 2,
    parameter int    ASSOC          = 2,
    parameter int    TAG_BITS       = 25,
    parameter word_t NONCACHE_START = 32'hF000_0000,
    localparam int   FRAME_W        = BLOCK_WORDS * 32 + TAG_BITS + 2,
    localparam int   SET_W          = ASSOC * FRAME_W,
    localparam int   WAY_W          = (ASSOC > 1) ? $clog2(ASSOC) : 1,
    localparam int   IDX_W          = $clog2(N_SETS)
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      flush,
    input  logic                      ren,
    input  logic                      wen,
    input  word_t                     addr,
    input  word_t                     wdata,
    input  byte_en_t                  byte_en,
    output logic                      busy,
    output word_t                     rdata,
    output logic                      flush_done,
    input  logic                      hit,
    input  logic [WAY_W-1:0]          hit_way,
    input  word_t                     hit_word,
    input  logic [WAY_W-1:0]          victim_way,
    input  logic                      victim_dirty,
    input  logic [TAG_BITS-1:0]       victim_tag,
    input  logic [SET_W-1:0]          rval,
    output logic                      touch,
    output logic [IDX_W-1:0]          sram_sel,
    output logic                      sram_wen,
    output logic [SET_W-1:0]          sram_wval,
    output logic [SET_W-1:0]          sram_wmask,
    output logic                      mem_ren,
    output logic                      mem_wen,
    output word_t                     mem_addr,
    output logic [BLOCK_WORDS*32-1:0] mem_wdata,
    output byte_en_t                  mem_byte_en,
    input  logic                      mem_busy,
    input  logic [BLOCK_WORDS*32-1:0] mem_rdata
);

    localparam int DATA_W = BLOCK_WORDS * 32;
    localparam int OFF_W  = $clog2(BLOCK_WORDS);
    localparam logic [SET_W-1:0] FRAME_ONES = SET_W'({FRAME_W{1'b1}});

    cache_state_t state, next_state;

    logic [IDX_W-1:0]   flush_set, addr_set, miss_set;
    logic [WAY_W-1:0]   flush_way;
    logic               flush_last, count_en;
    logic               flush_req, flush_pend;
    logic               req, pass_through, flush_dirty;
    word_t              miss_addr;    // block-aligned miss address
    word_t              word_off, lane_bits;
    logic [FRAME_W-1:0] flush_frame;
    int                 word_pos, dirty_pos, victim_pos, flush_pos;

    assign req          = ren || wen;
    assign pass_through = addr >= NONCACHE_START;
    assign flush_pend   = flush || flush_req;
    assign addr_set     = addr[2+OFF_W +: IDX_W];
    assign miss_set     = miss_addr[2+OFF_W +: IDX_W];
    assign word_off     = (addr >> 2) & word_t'(BLOCK_WORDS - 1);
    assign lane_bits    = {{8{byte_en[3]}}, {8{byte_en[2]}}, {8{byte_en[1]}}, {8{byte_en[0]}}};

    // bit offsets inside the set
    assign word_pos   = int'(hit_way) * FRAME_W + int'(word_off) * 32;
    assign dirty_pos  = int'(hit_way) * FRAME_W + FRAME_W - 2;
    assign victim_pos = int'(victim_way) * FRAME_W;
    assign flush_pos  = int'(flush_way) * FRAME_W;

    assign flush_frame = FRAME_W'(rval >> flush_pos);
    assign flush_dirty = flush_frame[FRAME_W-1] && flush_frame[FRAME_W-2];
    assign flush_last  = flush_set == IDX_W'(N_SETS - 1) && flush_way == WAY_W'(ASSOC - 1);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            flush_set <= '0;
            flush_way <= '0;
            flush_req <= 1'b0;
        end else begin
            state <= next_state;
            if (count_en) begin   // walk ways first, then sets
                if (flush_way == WAY_W'(ASSOC - 1)) begin
                    flush_way <= '0;
                    flush_set <= (flush_set == IDX_W'(N_SETS - 1)) ? '0 : flush_set + 1'b1;
                end else begin
                    flush_way <= flush_way + 1'b1;
                end
            end
            if (state != FLUSH_CACHE && next_state == FLUSH_CACHE) begin
                flush_req <= 1'b0;
            end else if (flush) begin
                flush_req <= 1'b1;   // hold a strobe seen outside HIT
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (state == HIT && (next_state == FETCH || next_state == WB)) begin
            miss_addr <= addr & ~word_t'(BLOCK_WORDS * 4 - 1);
        end
    end

    always_comb begin
        next_state  = state;
        busy        = 1'b1;
        rdata       = '0;
        flush_done  = 1'b0;
        touch       = 1'b0;
        count_en    = 1'b0;
        sram_sel    = addr_set;
        sram_wen    = 1'b0;
        sram_wval   = '0;
        sram_wmask  = '1;
        mem_ren     = 1'b0;
        mem_wen     = 1'b0;
        mem_addr    = '0;
        mem_wdata   = '0;
        mem_byte_en = '1;   // full lanes for block traffic

        case (state)
            IDLE: begin   // zero one frame per cycle
                sram_sel   = flush_set;
                sram_wen   = 1'b1;
                sram_wmask = ~(FRAME_ONES << flush_pos);
                count_en   = 1'b1;
                if (flush_last) begin
                    next_state = HIT;
                end
            end
            HIT: begin
                if (flush_pend) begin
                    next_state = FLUSH_CACHE;   // core request waits out the flush
                end else if (req && pass_through) begin
                    mem_ren     = ren;
                    mem_wen     = wen;
                    mem_addr    = addr;
                    mem_wdata   = DATA_W'(wdata & lane_bits);   // uncached word rides in word 0
                    mem_byte_en = byte_en;
                    busy        = mem_busy;
                    rdata       = mem_rdata[31:0];
                end else if (req && hit) begin
                    busy  = 1'b0;
                    rdata = hit_word;
                    touch = 1'b1;
                    if (wen) begin   // merge enabled lanes, mark dirty
                        sram_wen   = 1'b1;
                        sram_wval  = (SET_W'(wdata) << word_pos) | (SET_W'(1) << dirty_pos);
                        sram_wmask = ~((SET_W'(lane_bits) << word_pos)
                                       | (SET_W'(1) << dirty_pos));
                    end
                end else if (req) begin
                    next_state = victim_dirty ? WB : FETCH;
                end
            end
            FETCH: begin
                sram_sel = miss_set;
                mem_ren  = 1'b1;
                mem_addr = miss_addr;
                if (!mem_busy) begin   // fill: valid, clean, new tag
                    sram_wen   = 1'b1;
                    sram_wval  = SET_W'({2'b10, miss_addr[31 -: TAG_BITS], mem_rdata})
                                 << victim_pos;
                    sram_wmask = ~(FRAME_ONES << victim_pos);
                    next_state = HIT;
                end
            end
            WB: begin
                sram_sel  = miss_set;
                mem_wen   = 1'b1;
                mem_addr  = {victim_tag, miss_addr[31-TAG_BITS:0]};
                mem_wdata = DATA_W'(rval >> victim_pos);
                if (!mem_busy) begin
                    sram_wen   = 1'b1;
                    sram_wmask = ~(SET_W'(2'b11) << (victim_pos + FRAME_W - 2));   // drop valid, dirty
                    next_state = FETCH;
                end
            end
            FLUSH_CACHE: begin
                sram_sel = flush_set;
                if (flush_dirty) begin
                    mem_wen   = 1'b1;
                    mem_addr  = word_t'({flush_frame[DATA_W +: TAG_BITS], flush_set}) << (OFF_W + 2);
                    mem_wdata = flush_frame[DATA_W-1:0];
                end
                if (!flush_dirty || !mem_busy) begin   // clean frames take one cycle
                    sram_wen   = 1'b1;
                    sram_wmask = ~(FRAME_ONES << flush_pos);
                    count_en   = 1'b1;
                    if (flush_last) begin
                        flush_done = 1'b1;
                        next_state = HIT;
                    end
                end
            end
            default: next_state = IDLE;
        endcase
    end

endmodule

//--- l1_cache.sv
`timescale 1ns/1ns

module l1_cache import cache_pkg::*; #(
    parameter int    CACHE_BYTES    = DEF_CACHE_BYTES,
    parameter int    BLOCK_WORDS    = DEF_BLOCK_WORDS,
    parameter int    ASSOC          = DEF_ASSOC,            // 1 or 2
    parameter word_t NONCACHE_START = DEF_NONCACHE_START
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      flush,
    input  logic                      ren,
    input  logic                      wen,
    input  word_t                     addr,
    input  word_t                     wdata,
    input  byte_en_t                  byte_en,
    output logic                      busy,
    output word_t                     rdata,
    output logic                      flush_done,
    output logic                      mem_ren,
    output logic                      mem_wen,
    output word_t                     mem_addr,
    output logic [BLOCK_WORDS*32-1:0] mem_wdata,
    output byte_en_t                  mem_byte_en,
    input  logic                      mem_busy,
    input  logic [BLOCK_WORDS*32-1:0] mem_rdata
);

    localparam int N_SETS   = CACHE_BYTES / (4 * BLOCK_WORDS * ASSOC);
    localparam int TAG_BITS = 32 - $clog2(N_SETS) - $clog2(BLOCK_WORDS) - 2;
    localparam int FRAME_W  = BLOCK_WORDS * 32 + TAG_BITS + 2;   // data, tag, dirty, valid
    localparam int SET_W    = ASSOC * FRAME_W;
    localparam int WAY_W    = (ASSOC > 1) ? $clog2(ASSOC) : 1;
    localparam int IDX_W    = $clog2(N_SETS);

    logic [SET_W-1:0]    rval, sram_wval, sram_wmask;
    logic [IDX_W-1:0]    sram_sel;
    logic                sram_wen, touch;
    logic                hit, victim_dirty;
    logic [WAY_W-1:0]    hit_way, victim_way;
    word_t               hit_word;
    logic [TAG_BITS-1:0] victim_tag;

    cache_sram #(
        .N_SETS (N_SETS),
        .SET_W  (SET_W)
    ) sram_i (
        .CLK   (CLK),
        .nRST  (nRST),
        .sel   (sram_sel),
        .wen   (sram_wen),
        .wval  (sram_wval),
        .wmask (sram_wmask),
        .rval  (rval)
    );

    cache_lookup #(
        .N_SETS      (N_SETS),
        .BLOCK_WORDS (BLOCK_WORDS),
        .ASSOC       (ASSOC),
        .TAG_BITS    (TAG_BITS)
    ) lookup_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .rval         (rval),
        .addr         (addr),
        .touch        (touch),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_word     (hit_word),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    cache_ctrl #(
        .N_SETS         (N_SETS),
        .BLOCK_WORDS    (BLOCK_WORDS),
        .ASSOC          (ASSOC),
        .TAG_BITS       (TAG_BITS),
        .NONCACHE_START (NONCACHE_START)
    ) ctrl_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .flush        (flush),
        .ren          (ren),
        .wen          (wen),
        .addr         (addr),
        .wdata        (wdata),
        .byte_en      (byte_en),
        .busy         (busy),
        .rdata        (rdata),
        .flush_done   (flush_done),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_word     (hit_word),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .rval         (rval),
        .touch        (touch),
        .sram_sel     (sram_sel),
        .sram_wen     (sram_wen),
        .sram_wval    (sram_wval),
        .sram_wmask   (sram_wmask),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_byte_en  (mem_byte_en),
        .mem_busy     (mem_busy),
        .mem_rdata    (mem_rdata)
    );

endmodule

//--- cache_chk.sv
`timescale 1ns/1ns

module cache_chk import cache_pkg::*; (
    input logic         CLK,
    input logic         nRST,
    input cache_state_t state,
    input logic         busy,
    input logic         flush_done,
    input logic         mem_ren,
    input logic         mem_wen
);

    int violations = 0;

    // one memory direction at a time
    one_strobe: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else begin
            $error("mem_ren and mem_wen set in the same cycle");
            violations++;
        end

    done_in_flush: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |-> state == FLUSH_CACHE)
        else begin
            $error("flush_done outside FLUSH_CACHE");
            violations++;
        end

    // clear sweep keeps both buses quiet
    quiet_clear: assert property (@(posedge CLK) disable iff (!nRST)
        state == IDLE |-> busy && !mem_ren && !mem_wen)
        else begin
            $error("busy low or memory strobe set during the clear sweep");
            violations++;
        end

endmodule

bind cache_ctrl cache_chk chk_i (
    .CLK        (CLK),
    .nRST       (nRST),
    .state      (state),
    .busy       (busy),
    .flush_done (flush_done),
    .mem_ren    (mem_ren),
    .mem_wen    (mem_wen)
);

//--- tb_mem_model.sv
`timescale 1ns/1ns

module tb_mem_model import cache_pkg::*; #(
    parameter int    BLOCK_WORDS    = 2,
    parameter word_t UNCACHED_START = 32'hF000_0000,   // single-word region
    parameter int    LATENCY        = 3                // busy cycles per transfer
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      mem_ren,
    input  logic                      mem_wen,
    input  word_t                     mem_addr,
    input  logic [BLOCK_WORDS*32-1:0] mem_wdata,
    input  byte_en_t                  mem_byte_en,
    output logic                      mem_busy,
    output logic [BLOCK_WORDS*32-1:0] mem_rdata
);

    word_t store [word_t];   // written words only, keyed by word address
    int    wait_cnt;
    logic  req;

    assign req      = mem_ren || mem_wen;
    assign mem_busy = !(req && wait_cnt == LATENCY);

    // untouched words read as the inverse of their byte address
    function automatic word_t fetch_word(input word_t byte_addr);
        word_t key;
        key = byte_addr >> 2;
        if (store.exists(key)) begin
            return store[key];
        end
        return ~(key << 2);
    endfunction

    task automatic merge_word(input word_t byte_addr, input word_t data, input byte_en_t be);
        word_t w;
        w = fetch_word(byte_addr);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        store[byte_addr >> 2] = w;
    endtask

    // direct look at memory contents, no bus cycles
    task automatic peek_word(input word_t byte_addr, output word_t data);
        data = fetch_word(byte_addr);
    endtask

    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt  <= 0;
            mem_rdata <= '0;
        end else if (!req) begin
            wait_cnt <= 0;
        end else if (wait_cnt != LATENCY) begin
            wait_cnt <= wait_cnt + 1;
            for (int i = 0; i < BLOCK_WORDS; i++) begin   // ready by the answer cycle
                mem_rdata[i*32 +: 32] <= fetch_word(mem_addr + word_t'(4 * i));
            end
        end else begin
            wait_cnt <= 0;   // transfer ends on this edge
            if (mem_wen && mem_addr >= UNCACHED_START) begin
                merge_word(mem_addr, mem_wdata[31:0], mem_byte_en);
            end else if (mem_wen) begin
                for (int i = 0; i < BLOCK_WORDS; i++) begin
                    merge_word(mem_addr + word_t'(4 * i), mem_wdata[i*32 +: 32], mem_byte_en);
                end
            end
        end
    end

endmodule

//--- tb_l1_cache.sv
`timescale 1ns/1ns

module tb_l1_cache import cache_pkg::*; ();

    localparam int MAX_LINES     = 64;
    localparam int COLS          = 5;     // op, addr, wdata, byte_en, expected
    localparam int CYCLES_PER_OP = 200;
    localparam int BLOCK_BITS    = DEF_BLOCK_WORDS * 32;

    localparam word_t OP_READ   = 32'h0;
    localparam word_t OP_WRITE  = 32'h1;
    localparam word_t OP_FLUSH  = 32'h2;
    localparam word_t OP_MEMCHK = 32'h3;
    localparam word_t OP_END    = 32'hF;   // fills the table past the last line

    logic                  CLK;
    logic                  nRST;
    logic                  flush, ren, wen;
    word_t                 addr, wdata, rdata;
    byte_en_t              byte_en, mem_byte_en;
    logic                  busy, flush_done;
    logic                  mem_ren, mem_wen, mem_busy;
    word_t                 mem_addr;
    logic [BLOCK_BITS-1:0] mem_wdata, mem_rdata;

    word_t gold [MAX_LINES*COLS];
    int    n_lines     = 0;
    int    errors      = 0;
    int    n_pass      = 0;
    int    n_fail      = 0;
    int    cycles      = 0;
    int    cycle_limit = 0;

    l1_cache l1_cache_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .flush       (flush),
        .ren         (ren),
        .wen         (wen),
        .addr        (addr),
        .wdata       (wdata),
        .byte_en     (byte_en),
        .busy        (busy),
        .rdata       (rdata),
        .flush_done  (flush_done),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_byte_en (mem_byte_en),
        .mem_busy    (mem_busy),
        .mem_rdata   (mem_rdata)
    );

    tb_mem_model #(
        .BLOCK_WORDS    (DEF_BLOCK_WORDS),
        .UNCACHED_START (DEF_NONCACHE_START),
        .LATENCY        (3)
    ) mem_i (
        .CLK         (CLK),
        .nRST        (nRST),
        .mem_ren     (mem_ren),
        .mem_wen     (mem_wen),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_byte_en (mem_byte_en),
        .mem_busy    (mem_busy),
        .mem_rdata   (mem_rdata)
    );

    initial begin
        CLK = 1'b0;
    end

    always #5 CLK = ~CLK;

    // watchdog, limit set once the golden file is loaded
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, a request or flush never completed", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic compare(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("mismatch %s exp %h got %h", name, expected, actual);
            errors++;
        end
    endtask

    function automatic string op_name(input word_t op);
        case (op)
            OP_READ:   return "read";
            OP_WRITE:  return "write";
            OP_FLUSH:  return "flush";
            OP_MEMCHK: return "memcheck";
            default:   return "unknown";
        endcase
    endfunction

    task automatic core_access(input logic is_write, input word_t a, input word_t d,
                               input byte_en_t be, output word_t got, output int waits);
        waits = 0;
        @(posedge CLK);
        ren     <= !is_write;
        wen     <= is_write;
        addr    <= a;
        wdata   <= d;
        byte_en <= be;
        @(negedge CLK);
        while (busy) begin   // request held until the cache answers
            waits++;
            @(negedge CLK);
        end
        got = rdata;
        @(posedge CLK);
        ren <= 1'b0;
        wen <= 1'b0;
    endtask

    task automatic request_flush();
        @(posedge CLK);
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        @(negedge CLK);
        while (!flush_done) begin
            @(negedge CLK);
        end
        @(negedge CLK);
        compare("flush_done", 32'h0, word_t'(flush_done));   // one cycle only
    endtask

    task automatic run_line(input int idx);
        word_t    op;
        word_t    a;
        word_t    d;
        word_t    expected;
        word_t    got;
        byte_en_t be;
        int       errors_before;
        int       waits;

        op            = gold[idx*COLS];
        a             = gold[idx*COLS+1];
        d             = gold[idx*COLS+2];
        be            = byte_en_t'(gold[idx*COLS+3]);
        expected      = gold[idx*COLS+4];
        errors_before = errors;
        case (op)
            OP_READ: begin
                core_access(1'b0, a, d, be, got, waits);
                compare("rdata", expected, got);
                // back-to-back read of one address is a hit, no added cycles
                if (idx > 0 && gold[(idx-1)*COLS] == OP_READ
                        && gold[(idx-1)*COLS+1] == a) begin
                    compare("busy_cycles", 32'h0, word_t'(waits));
                end
            end
            OP_WRITE: begin
                core_access(1'b1, a, d, be, got, waits);
            end
            OP_FLUSH: begin
                request_flush();
            end
            OP_MEMCHK: begin
                @(negedge CLK);   // last write-back edge has passed
                mem_i.peek_word(a, got);
                compare("mem_word", expected, got);
            end
            default: begin
                $display("golden line %0d has an unknown operation code %h", idx, op);
                errors++;
            end
        endcase
        if (errors == errors_before) begin
            n_pass++;
            $display("test %0d %s %h ok", idx, op_name(op), a);
        end else begin
            n_fail++;
            $display("test %0d %s %h failed", idx, op_name(op), a);
        end
    endtask

    initial begin
        nRST    <= 1'b0;
        flush   <= 1'b0;
        ren     <= 1'b0;
        wen     <= 1'b0;
        addr    <= '0;
        wdata   <= '0;
        byte_en <= '0;
        for (int i = 0; i < MAX_LINES * COLS; i++) begin
            gold[i] = OP_END;
        end
        $readmemh("cache_golden.txt", gold);
        while (n_lines < MAX_LINES && gold[n_lines*COLS] != OP_END) begin
            n_lines++;
        end
        cycle_limit = n_lines * CYCLES_PER_OP;
        if (n_lines == 0) begin
            $display("golden file cache_golden.txt holds no operations");
            errors++;
        end

        repeat (16) @(posedge CLK);
        nRST <= 1'b1;   // clear sweep starts here

        for (int i = 0; i < n_lines; i++) begin
            run_line(i);
        end

        if (l1_cache_i.ctrl_i.chk_i.violations != 0) begin
            $display("protocol checker saw %0d assertion failures",
                     l1_cache_i.ctrl_i.chk_i.violations);
            errors++;
        end
        $display("tests run %0d, passed %0d, failed %0d", n_lines, n_pass, n_fail);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- cache_golden.txt
// op codes: 0 read, 1 write, 2 flush, 3 memory check
// columns: op  address  write data  byte_en  expected word
0 00000100 00000000 f fffffeff  // read miss, clean fill
0 00000100 00000000 f fffffeff  // same address hits
1 00000104 aabbccdd 5 00000000  // write hit, lanes 0 and 2
0 00000104 00000000 f ffbbfedd
0 00000200 00000000 f fffffdff  // second tag in set 0
0 00000300 00000000 f fffffcff  // third tag evicts the dirty block
3 00000104 00000000 0 ffbbfedd
3 00000100 00000000 0 fffffeff
0 00000104 00000000 f ffbbfedd  // evicted block comes back
1 00000010 11111111 f 00000000  // write miss, set 2
1 00000028 22222222 f 00000000  // set 5
1 00000044 33333333 c 00000000  // set 8, upper lanes
1 00000104 44444444 2 00000000  // set 0, lane 1
2 00000000 00000000 0 00000000
3 00000010 00000000 0 11111111
3 00000028 00000000 0 22222222
3 00000044 00000000 0 3333ffbb
3 00000104 00000000 0 ffbb44dd
3 00000014 00000000 0 ffffffeb  // unwritten word of a flushed block
0 00000028 00000000 f 22222222
0 00000044 00000000 f 3333ffbb
0 00000104 00000000 f ffbb44dd
1 f0000010 12345678 3 00000000  // uncached, lanes 0 and 1
0 f0000010 00000000 f 0fff5678
3 f0000010 00000000 0 0fff5678
3 f0000014 00000000 0 0fffffeb

//--- flist.f
cache_pkg.sv
cache_sram.sv
cache_lookup.sv
cache_ctrl.sv
l1_cache.sv
cache_chk.sv
tb_mem_model.sv
tb_l1_cache.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP      = tb_l1_cache
FLIST    = flist.f
LOG      = sim.log
RUNFLAGS = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || { echo "simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
